/* logic/stm_pkg.sv */
package stm_pkg;

  localparam int NUM_SEGMENT = 2;
  localparam int SEG_W = $clog2(NUM_SEGMENT);
  localparam int IDX_W = 13;
  localparam int REP_W = 16;
  localparam int DIV_W = 16;
  localparam int DATA_W = 16;

  // Repeat value that keeps a segment looping forever
  localparam logic [REP_W-1:0] REP_INFINITE = '1;

  typedef enum logic [7:0] {
    MODE_SYNC_IDX  = 8'h00,
    MODE_SYS_TIME  = 8'h01,
    MODE_GPIO      = 8'h02,
    MODE_EXT       = 8'hF0, // Immediate, then toggles segments at each wrap
    MODE_IMMEDIATE = 8'hFF
  } transition_mode_t;

  typedef enum logic [1:0] {
    WAIT_START,
    FINITE_LOOP,
    INFINITE_LOOP
  } swap_state_t;

  // Index source of the live segment
  typedef enum logic {
    IDX_SYNC, // Follows the timer's sync index
    IDX_TIC   // Own counter, restarted at the transition
  } idx_mode_t;

endpackage

/* logic/time_pkg.sv */
package time_pkg;

  localparam int SYS_TIME_W = 56;
  localparam int EC_TIME_W = 64;
  localparam int TICK_NS = 25;

  // Reciprocal of the tick length, rounded up
  // Exact for EC times below 2^64/9, which covers every 56-bit system time
  localparam int RECIP_SHIFT = 64;
  localparam logic [RECIP_SHIFT:0] RECIP_ONE = {1'b1, {RECIP_SHIFT{1'b0}}};
  localparam logic [EC_TIME_W-1:0] RECIP_MUL =
    EC_TIME_W'((RECIP_ONE + TICK_NS - 1) / TICK_NS);

  localparam int CONV_LATENCY = 3;
  localparam int DIFF_LATENCY = 2;

endpackage

/* logic/stm_settings_if.sv */
interface stm_settings_if;

  logic                              update;
  logic [stm_pkg::SEG_W-1:0]         req_segment;
  stm_pkg::transition_mode_t         transition_mode;
  logic [time_pkg::EC_TIME_W-1:0]    transition_value;
  logic [stm_pkg::IDX_W-1:0]         cycle [stm_pkg::NUM_SEGMENT];
  logic [stm_pkg::REP_W-1:0]         rep [stm_pkg::NUM_SEGMENT];
  logic [stm_pkg::DIV_W-1:0]         freq_div [stm_pkg::NUM_SEGMENT];

  modport settings_mp (
    output update, req_segment, transition_mode, transition_value,
    output cycle, rep, freq_div
  );

  modport timer_mp (
    input cycle, freq_div
  );

  modport swap_mp (
    input update, req_segment, transition_mode, transition_value,
    input cycle, rep
  );

endinterface

/* logic/stm_settings.sv */
module stm_settings (
  input  logic                              CLK,
  input  logic                              rst,
  input  logic                              cfg_wr,
  input  logic [stm_pkg::SEG_W-1:0]         cfg_segment,
  input  logic [stm_pkg::IDX_W-1:0]         cfg_cycle,
  input  logic [stm_pkg::REP_W-1:0]         cfg_rep,
  input  logic [stm_pkg::DIV_W-1:0]         cfg_freq_div,
  input  logic                              swap_req,
  input  logic [stm_pkg::SEG_W-1:0]         req_segment,
  input  stm_pkg::transition_mode_t         transition_mode,
  input  logic [time_pkg::EC_TIME_W-1:0]    transition_value,
  stm_settings_if.settings_mp               cfg
);

  // Per-segment settings
  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < stm_pkg::NUM_SEGMENT; i++) begin
        cfg.cycle[i]    <= '0;
        cfg.rep[i]      <= stm_pkg::REP_INFINITE;
        cfg.freq_div[i] <= '0;
      end
    end else if (cfg_wr) begin
      cfg.cycle[cfg_segment]    <= cfg_cycle;
      cfg.rep[cfg_segment]      <= cfg_rep;
      cfg.freq_div[cfg_segment] <= cfg_freq_div;
    end
  end

  // Request fields held until the next swap
  always_ff @(posedge CLK) begin
    if (swap_req) begin
      cfg.req_segment      <= req_segment;
      cfg.transition_mode  <= transition_mode;
      cfg.transition_value <= transition_value;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      cfg.update <= 1'b0;
    end else begin
      cfg.update <= swap_req; // Lines up with the latched fields
    end
  end

endmodule

/* logic/stm_timer.sv */
module stm_timer (
  input  logic                              CLK,
  input  logic                              rst,
  input  logic [time_pkg::SYS_TIME_W-1:0]   sys_time,
  stm_settings_if.timer_mp                  cfg,
  output logic [stm_pkg::IDX_W-1:0]         sync_idx [stm_pkg::NUM_SEGMENT]
);

  logic [time_pkg::SYS_TIME_W-1:0] sys_time_q;
  logic                            tick;
  logic [stm_pkg::DIV_W-1:0]       div_cnt [stm_pkg::NUM_SEGMENT];

  always_ff @(posedge CLK) begin
    if (rst) begin
      sys_time_q <= '0;
    end else begin
      sys_time_q <= sys_time;
    end
  end

  assign tick = sys_time != sys_time_q; // One per system time step

  // Both segments always run so a waiting segment can be watched
  for (genvar i = 0; i < stm_pkg::NUM_SEGMENT; i++) begin : g_seg
    always_ff @(posedge CLK) begin
      if (rst) begin
        div_cnt[i]  <= '0;
        sync_idx[i] <= '0;
      end else if (div_cnt[i] == cfg.freq_div[i]) begin
        div_cnt[i] <= '0;
        if (sync_idx[i] >= cfg.cycle[i]) begin // Also catches a shortened cycle
          sync_idx[i] <= '0;
        end else begin
          sync_idx[i] <= sync_idx[i] + 1'b1;
        end
      end else if (tick) begin
        div_cnt[i] <= div_cnt[i] + 1'b1;
      end
    end
  end

endmodule

/* logic/ec_time_to_sys_time.sv */
module ec_time_to_sys_time (
  input  logic                              CLK,
  input  logic                              rst,
  input  logic [time_pkg::EC_TIME_W-1:0]    ec_time,
  input  logic                              din_valid,
  output logic [time_pkg::SYS_TIME_W-1:0]   sys_time_out,
  output logic                              dout_valid
);

  logic [time_pkg::EC_TIME_W-1:0]   ec_q;
  logic [2*time_pkg::EC_TIME_W-1:0] prod;
  logic [time_pkg::CONV_LATENCY-1:0] valid_pipe;

  // Divide by the tick length as multiply and shift
  always_ff @(posedge CLK) begin
    ec_q         <= ec_time;
    prod         <= (2*time_pkg::EC_TIME_W)'(ec_q) * time_pkg::RECIP_MUL;
    sys_time_out <= prod[time_pkg::RECIP_SHIFT +: time_pkg::SYS_TIME_W];
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[time_pkg::CONV_LATENCY-2:0], din_valid};
    end
  end

  assign dout_valid = valid_pipe[time_pkg::CONV_LATENCY-1];

endmodule

/* logic/stm_swapchain.sv */
module stm_swapchain (
  input  logic                              CLK,
  input  logic                              rst,
  input  logic [time_pkg::SYS_TIME_W-1:0]   sys_time,
  input  logic [3:0]                        gpio_in,
  input  logic [stm_pkg::IDX_W-1:0]         sync_idx [stm_pkg::NUM_SEGMENT],
  stm_settings_if.swap_mp                   cfg,
  output logic [stm_pkg::SEG_W-1:0]         segment,
  output logic [stm_pkg::IDX_W-1:0]         idx,
  output logic                              stop
);

  stm_pkg::swap_state_t              state;
  stm_pkg::idx_mode_t                idx_mode;
  logic                              ext_mode;
  logic [stm_pkg::SEG_W-1:0]         req_seg;
  logic [stm_pkg::REP_W-1:0]         rep;
  logic [stm_pkg::REP_W-1:0]         loop_cnt;
  logic [stm_pkg::IDX_W-1:0]         idx_old [stm_pkg::NUM_SEGMENT];
  logic [stm_pkg::IDX_W-1:0]         tic_idx [stm_pkg::NUM_SEGMENT];
  logic                              idx_changed [stm_pkg::NUM_SEGMENT];
  logic                              idx_wrap [stm_pkg::NUM_SEGMENT];
  logic                              conv_din_valid;
  logic                              conv_dout_valid;
  logic [time_pkg::SYS_TIME_W-1:0]   transition_time;
  logic [time_pkg::SYS_TIME_W:0]     time_diff;
  logic                              wait_transition;
  logic [$clog2(time_pkg::DIFF_LATENCY)-1:0] diff_cnt;
  logic                              fire;
  logic                              loop_wrap;

  ec_time_to_sys_time u_ec_time_to_sys_time (
    .CLK          (CLK),
    .rst          (rst),
    .ec_time      (cfg.transition_value),
    .din_valid    (conv_din_valid),
    .sys_time_out (transition_time),
    .dout_valid   (conv_dout_valid)
  );

  always_ff @(posedge CLK) begin
    if (rst) begin
      conv_din_valid <= 1'b0;
    end else begin
      conv_din_valid <= cfg.update && (cfg.transition_mode == stm_pkg::MODE_SYS_TIME);
    end
  end

  // Sign bit set while sys_time is still before the transition time
  always_ff @(posedge CLK) begin
    time_diff <= {1'b0, sys_time} - {1'b0, transition_time};
  end

  for (genvar i = 0; i < stm_pkg::NUM_SEGMENT; i++) begin : g_seg
    always_ff @(posedge CLK) begin
      if (rst) begin
        idx_old[i] <= '0;
      end else begin
        idx_old[i] <= sync_idx[i];
      end
    end
    assign idx_changed[i] = idx_old[i] != sync_idx[i];
    assign idx_wrap[i]    = idx_changed[i] && (sync_idx[i] == '0);
  end

  assign idx = (idx_mode == stm_pkg::IDX_SYNC) ? idx_old[segment] : tic_idx[segment];

  always_comb begin
    case (cfg.transition_mode)
      stm_pkg::MODE_SYNC_IDX: fire = idx_wrap[req_seg];
      stm_pkg::MODE_SYS_TIME: fire = !wait_transition && !time_diff[time_pkg::SYS_TIME_W] &&
        (diff_cnt == $bits(diff_cnt)'(time_pkg::DIFF_LATENCY - 1));
      stm_pkg::MODE_GPIO:     fire = idx_changed[req_seg] && gpio_in[cfg.transition_value[1:0]];
      default:                fire = 1'b0;
    endcase
  end

  // One pass of the live segment completed
  assign loop_wrap = (idx_mode == stm_pkg::IDX_SYNC) ? idx_wrap[segment] :
    (idx_changed[segment] && (tic_idx[segment] >= cfg.cycle[segment]));

  always_ff @(posedge CLK) begin
    if (cfg.update) begin
      rep     <= cfg.rep[cfg.req_segment];
      req_seg <= cfg.req_segment;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      state           <= stm_pkg::INFINITE_LOOP;
      idx_mode        <= stm_pkg::IDX_SYNC;
      ext_mode        <= 1'b0;
      segment         <= '0;
      stop            <= 1'b0;
      loop_cnt        <= '0;
      wait_transition <= 1'b0;
      diff_cnt        <= '0;
      for (int i = 0; i < stm_pkg::NUM_SEGMENT; i++) tic_idx[i] <= '0;
    end else if (cfg.update) begin
      stop     <= 1'b0;
      loop_cnt <= '0;
      if (cfg.rep[cfg.req_segment] == stm_pkg::REP_INFINITE) begin
        segment  <= cfg.req_segment;
        idx_mode <= stm_pkg::IDX_SYNC;
        ext_mode <= cfg.transition_mode == stm_pkg::MODE_EXT;
        state    <= stm_pkg::INFINITE_LOOP;
      end else if (cfg.transition_mode inside {stm_pkg::MODE_IMMEDIATE, stm_pkg::MODE_EXT}) begin
        segment  <= cfg.req_segment;
        idx_mode <= stm_pkg::IDX_SYNC;
        ext_mode <= 1'b0;
        state    <= stm_pkg::FINITE_LOOP;
      end else begin
        wait_transition <= 1'b1;
        diff_cnt        <= '0;
        state           <= stm_pkg::WAIT_START;
      end
    end else begin
      case (state)
        stm_pkg::WAIT_START: begin
          if (wait_transition) begin
            if (conv_dout_valid) wait_transition <= 1'b0;
          end else if (diff_cnt != $bits(diff_cnt)'(time_pkg::DIFF_LATENCY - 1)) begin
            diff_cnt <= diff_cnt + 1'b1; // Let time_diff see the new transition time
          end
          if (fire) begin
            segment  <= req_seg;
            ext_mode <= 1'b0;
            state    <= stm_pkg::FINITE_LOOP;
            if (cfg.transition_mode == stm_pkg::MODE_SYNC_IDX) begin
              idx_mode <= stm_pkg::IDX_SYNC;
            end else begin
              idx_mode         <= stm_pkg::IDX_TIC;
              tic_idx[req_seg] <= '0;
            end
          end
        end
        stm_pkg::INFINITE_LOOP: begin
          if (ext_mode && idx_wrap[segment]) segment <= ~segment;
        end
        stm_pkg::FINITE_LOOP: begin
          if (idx_mode == stm_pkg::IDX_TIC && idx_changed[segment]) begin
            tic_idx[segment] <= loop_wrap ? '0 : tic_idx[segment] + 1'b1;
          end
          if (loop_wrap) begin
            if (loop_cnt == rep) stop <= 1'b1; // rep+1 passes done
            else loop_cnt <= loop_cnt + 1'b1;
          end
        end
        default: state <= stm_pkg::INFINITE_LOOP;
      endcase
    end
  end

endmodule

/* logic/stm_memory.sv */
module stm_memory (
  input  logic                              CLK,
  input  logic                              rst,
  input  logic                              mem_wr,
  input  logic [stm_pkg::SEG_W-1:0]         mem_segment,
  input  logic [stm_pkg::IDX_W-1:0]         mem_addr,
  input  logic [stm_pkg::DATA_W-1:0]        mem_data,
  input  logic [stm_pkg::SEG_W-1:0]         segment,
  input  logic [stm_pkg::IDX_W-1:0]         idx,
  input  logic                              stop,
  output logic [stm_pkg::DATA_W-1:0]        pattern_out,
  output logic [stm_pkg::SEG_W-1:0]         segment_out,
  output logic [stm_pkg::IDX_W-1:0]         idx_out,
  output logic                              stop_out
);

  // Both segments share one array, addressed by {segment, index}
  logic [stm_pkg::DATA_W-1:0] ram [stm_pkg::NUM_SEGMENT * 2**stm_pkg::IDX_W];

  always_ff @(posedge CLK) begin
    if (mem_wr) begin
      ram[{mem_segment, mem_addr}] <= mem_data;
    end
  end

  always_ff @(posedge CLK) begin
    pattern_out <= ram[{segment, idx}];
  end

  // Control delayed by the read latency
  always_ff @(posedge CLK) begin
    if (rst) begin
      segment_out <= '0;
      idx_out     <= '0;
      stop_out    <= 1'b0;
    end else begin
      segment_out <= segment;
      idx_out     <= idx;
      stop_out    <= stop;
    end
  end

endmodule

/* logic/stm_top.sv */
module stm_top (
  input  logic                              CLK,
  input  logic                              rst,
  input  logic [time_pkg::SYS_TIME_W-1:0]   sys_time,
  input  logic [3:0]                        gpio_in,
  input  logic                              cfg_wr,
  input  logic [stm_pkg::SEG_W-1:0]         cfg_segment,
  input  logic [stm_pkg::IDX_W-1:0]         cfg_cycle,
  input  logic [stm_pkg::REP_W-1:0]         cfg_rep,
  input  logic [stm_pkg::DIV_W-1:0]         cfg_freq_div,
  input  logic                              swap_req,
  input  logic [stm_pkg::SEG_W-1:0]         req_segment,
  input  stm_pkg::transition_mode_t         transition_mode,
  input  logic [time_pkg::EC_TIME_W-1:0]    transition_value,
  input  logic                              mem_wr,
  input  logic [stm_pkg::SEG_W-1:0]         mem_segment,
  input  logic [stm_pkg::IDX_W-1:0]         mem_addr,
  input  logic [stm_pkg::DATA_W-1:0]        mem_data,
  output logic [stm_pkg::DATA_W-1:0]        pattern_out,
  output logic [stm_pkg::SEG_W-1:0]         segment_out,
  output logic [stm_pkg::IDX_W-1:0]         idx_out,
  output logic                              stop
);

  stm_settings_if cfg ();

  logic [stm_pkg::IDX_W-1:0] sync_idx [stm_pkg::NUM_SEGMENT];
  logic [stm_pkg::SEG_W-1:0] segment;
  logic [stm_pkg::IDX_W-1:0] idx;
  logic                      swap_stop;

  stm_settings u_settings (
    .CLK, .rst,
    .cfg_wr, .cfg_segment, .cfg_cycle, .cfg_rep, .cfg_freq_div,
    .swap_req, .req_segment, .transition_mode, .transition_value,
    .cfg (cfg.settings_mp)
  );

  stm_timer u_timer (
    .CLK, .rst, .sys_time,
    .cfg      (cfg.timer_mp),
    .sync_idx (sync_idx)
  );

  stm_swapchain u_swapchain (
    .CLK, .rst, .sys_time, .gpio_in, .sync_idx,
    .cfg     (cfg.swap_mp),
    .segment (segment),
    .idx     (idx),
    .stop    (swap_stop)
  );

  stm_memory u_memory (
    .CLK, .rst, .mem_wr, .mem_segment, .mem_addr, .mem_data,
    .segment, .idx,
    .stop        (swap_stop),
    .pattern_out, .segment_out, .idx_out,
    .stop_out    (stop)
  );

endmodule

/* dv/stm_asserts.sv */
module stm_asserts (
  input logic                      CLK,
  input logic                      rst,
  input logic [stm_pkg::SEG_W-1:0] segment,
  input logic [stm_pkg::IDX_W-1:0] idx,
  input logic                      stop,
  input stm_pkg::swap_state_t      state,
  input logic                      update,
  input logic [stm_pkg::IDX_W-1:0] cycle [stm_pkg::NUM_SEGMENT],
  input logic                      idx_changed [stm_pkg::NUM_SEGMENT]
);

  idx_in_range: assert property (@(posedge CLK) disable iff (rst)
    idx <= cycle[segment])
    else $error("live index above the live cycle");

  // Only a finite loop may finish
  stop_from_finite: assert property (@(posedge CLK) disable iff (rst)
    $rose(stop) |-> $past(state) == stm_pkg::FINITE_LOOP)
    else $error("stop rose outside FINITE_LOOP");

  segment_change_cause: assert property (@(posedge CLK) disable iff (rst)
    $changed(segment) |-> $past(update) || $past(idx_changed[0] || idx_changed[1]))
    else $error("segment changed without update or index step");

endmodule

/* dv/stm_tb.sv */
module stm_tb;

  logic                            CLK;
  logic                            rst;
  logic [time_pkg::SYS_TIME_W-1:0] sys_time;
  logic [3:0]                      gpio_in;
  logic                            cfg_wr;
  logic [stm_pkg::SEG_W-1:0]       cfg_segment;
  logic [stm_pkg::IDX_W-1:0]       cfg_cycle;
  logic [stm_pkg::REP_W-1:0]       cfg_rep;
  logic [stm_pkg::DIV_W-1:0]       cfg_freq_div;
  logic                            swap_req;
  logic [stm_pkg::SEG_W-1:0]       req_segment;
  stm_pkg::transition_mode_t       transition_mode;
  logic [time_pkg::EC_TIME_W-1:0]  transition_value;
  logic                            mem_wr;
  logic [stm_pkg::SEG_W-1:0]       mem_segment;
  logic [stm_pkg::IDX_W-1:0]       mem_addr;
  logic [stm_pkg::DATA_W-1:0]      mem_data;
  logic [stm_pkg::DATA_W-1:0]      pattern_out;
  logic [stm_pkg::SEG_W-1:0]       segment_out;
  logic [stm_pkg::IDX_W-1:0]       idx_out;
  logic                            stop;

  integer                     seed;
  logic [stm_pkg::DATA_W-1:0] model [stm_pkg::NUM_SEGMENT][16]; // Reference pattern words
  logic [stm_pkg::IDX_W-1:0]  cycle_model [stm_pkg::NUM_SEGMENT];
  logic                       loaded;

  stm_top dut (.*);

  bind stm_swapchain stm_asserts u_asserts (
    .CLK, .rst, .segment, .idx, .stop, .state,
    .update      (cfg.update),
    .cycle       (cfg.cycle),
    .idx_changed (idx_changed)
  );

  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  always @(negedge CLK) sys_time <= sys_time + 1'b1;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("mismatch %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // Waits one clock and compares the readout against the model
  task automatic sample_cycle(input string name);
    @(negedge CLK);
    if (idx_out > cycle_model[segment_out]) begin
      report_failure($sformatf("%s: index %0d is above the cycle of segment %0d",
                               name, idx_out, segment_out));
    end
    if (loaded) check(name, model[segment_out][idx_out[3:0]], pattern_out);
  endtask

  task automatic write_settings(input int seg, input int cyc, input int rep, input int div);
    cfg_wr       = 1'b1;
    cfg_segment  = (stm_pkg::SEG_W)'(seg);
    cfg_cycle    = (stm_pkg::IDX_W)'(cyc);
    cfg_rep      = (stm_pkg::REP_W)'(rep);
    cfg_freq_div = (stm_pkg::DIV_W)'(div);
    cycle_model[seg] = (stm_pkg::IDX_W)'(cyc);
    sample_cycle("settings write");
    cfg_wr = 1'b0;
  endtask

  task automatic request_swap(input int seg, input stm_pkg::transition_mode_t mode,
                              input logic [63:0] value);
    swap_req         = 1'b1;
    req_segment      = (stm_pkg::SEG_W)'(seg);
    transition_mode  = mode;
    transition_value = value;
    sample_cycle("swap request");
    swap_req = 1'b0;
  endtask

  task automatic wait_for_segment(input string name, input int seg, input int limit);
    int n;
    n = 0;
    while (segment_out != seg && n < limit) begin
      sample_cycle(name);
      n++;
    end
    if (segment_out != seg) begin
      report_failure($sformatf("%s: timed out waiting for segment %0d", name, seg));
    end
  endtask

  task automatic test_reset_readout();
    check("reset segment", 0, segment_out);
    check("reset stop", 0, stop);
    write_settings(0, 7, stm_pkg::REP_INFINITE, 1);
    write_settings(1, 5, stm_pkg::REP_INFINITE, 0);
    for (int s = 0; s < stm_pkg::NUM_SEGMENT; s++) begin
      for (int a = 0; a < 16; a++) begin
        model[s][a] = (stm_pkg::DATA_W)'($random(seed));
        mem_wr      = 1'b1;
        mem_segment = (stm_pkg::SEG_W)'(s);
        mem_addr    = (stm_pkg::IDX_W)'(a);
        mem_data    = model[s][a];
        sample_cycle("pattern load");
      end
    end
    mem_wr = 1'b0;
    loaded = 1'b1; // Next read sees every word written
    repeat (40) sample_cycle("readout");
  endtask

  task automatic test_immediate_swap();
    request_swap(1, stm_pkg::MODE_IMMEDIATE, '0);
    wait_for_segment("immediate swap", 1, 10);
    repeat (30) begin
      sample_cycle("immediate readout");
      check("immediate stop", 0, stop);
    end
  endtask

  task automatic test_finite_loop();
    int wraps;
    int n;
    logic [stm_pkg::IDX_W-1:0] prev_idx;
    write_settings(0, 7, 2, 1);
    request_swap(0, stm_pkg::MODE_SYNC_IDX, '0);
    wait_for_segment("finite loop start", 0, 40);
    check("finite loop first index", 0, idx_out);
    wraps    = 0;
    n        = 0;
    prev_idx = idx_out;
    while (!stop && n < 200) begin
      sample_cycle("finite loop");
      if (idx_out == 0 && prev_idx != 0) wraps++;
      prev_idx = idx_out;
      n++;
    end
    if (!stop) report_failure("finite loop: stop never rose");
    check("finite loop wraps", 3, wraps); // rep 2 gives three passes
  endtask

  task automatic test_sys_time_swap();
    logic [time_pkg::SYS_TIME_W-1:0] t_fire;
    write_settings(1, 5, 3, 0);
    t_fire = sys_time + 300;
    request_swap(1, stm_pkg::MODE_SYS_TIME, {8'h00, t_fire} * 64'd25);
    wait_for_segment("sys time swap", 1, 400);
    if (sys_time < t_fire) report_failure("sys time swap: segment changed before the set time");
    if (sys_time > t_fire + 8) report_failure("sys time swap: segment changed too late");
    check("sys time first index", 0, idx_out);
  endtask

  task automatic test_gpio_swap();
    gpio_in = 4'b1011; // Only the selected line is low
    request_swap(0, stm_pkg::MODE_GPIO, 64'd2);
    repeat (40) begin
      sample_cycle("gpio hold");
      check("gpio hold segment", 1, segment_out);
    end
    gpio_in = 4'b0100;
    wait_for_segment("gpio swap", 0, 20);
    check("gpio first index", 0, idx_out);
  endtask

  task automatic test_ext_mode();
    int toggles;
    int n;
    logic [stm_pkg::SEG_W-1:0] prev_seg;
    logic [stm_pkg::IDX_W-1:0] prev_idx;
    write_settings(1, 5, stm_pkg::REP_INFINITE, 0);
    request_swap(1, stm_pkg::MODE_EXT, '0);
    wait_for_segment("ext start", 1, 10);
    toggles  = 0;
    n        = 0;
    prev_seg = segment_out;
    prev_idx = idx_out;
    while (toggles < 6 && n < 200) begin
      sample_cycle("ext readout");
      check("ext stop", 0, stop);
      if (segment_out != prev_seg) begin
        check("ext wrap index", cycle_model[prev_seg], prev_idx); // Left at the end of a pass
        toggles++;
      end
      prev_seg = segment_out;
      prev_idx = idx_out;
      n++;
    end
    if (toggles < 6) report_failure("ext mode: segment stopped toggling");
  endtask

  initial begin
    seed             = 60028;
    rst              = 1'b1;
    sys_time         = '0;
    gpio_in          = '0;
    cfg_wr           = 1'b0;
    cfg_segment      = '0;
    cfg_cycle        = '0;
    cfg_rep          = '0;
    cfg_freq_div     = '0;
    swap_req         = 1'b0;
    req_segment      = '0;
    transition_mode  = stm_pkg::MODE_IMMEDIATE;
    transition_value = '0;
    mem_wr           = 1'b0;
    mem_segment      = '0;
    mem_addr         = '0;
    mem_data         = '0;
    loaded           = 1'b0;
    cycle_model[0]   = '0;
    cycle_model[1]   = '0;
    repeat (16) @(negedge CLK);
    rst = 1'b0;
    test_reset_readout();
    test_immediate_swap();
    test_finite_loop();
    test_sys_time_swap();
    test_gpio_swap();
    test_ext_mode();
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* compile.f */
logic/stm_pkg.sv
logic/time_pkg.sv
logic/stm_settings_if.sv
logic/stm_settings.sv
logic/stm_timer.sv
logic/ec_time_to_sys_time.sv
logic/stm_swapchain.sv
logic/stm_memory.sv
logic/stm_top.sv
dv/stm_asserts.sv
dv/stm_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module stm_tb -f compile.f -o sim_stm \
  && ./obj_dir/sim_stm > sim.log 2>&1
status=$?
cat sim.log
[ "$status" -eq 0 ] && ! grep -q "Result: FAILED" sim.log && exit 0 || exit 1
